//--- filelist.f
+incdir+design
design/uart_pkg.sv
design/uart_if.sv
design/uart_tx.sv
design/uart_rx.sv
design/uart_regs.sv
design/uart_periph.sv
dv/tb_uart_periph.sv

//--- Makefile
# Verilator build and run of the UART peripheral testbench

SIM = obj_dir/sim_uart

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	verilator --binary --timing --timescale 1ns/1ns \
	  --top-module tb_uart_periph -f filelist.f \
	  --Mdir obj_dir -o sim_uart
	./$(SIM)

clean:
	rm -rf obj_dir

//--- dv/tb_uart_periph.sv
`timescale 1ns/1ns
`default_nettype none

`include "uart_consts.svh"

module tb_uart_periph
  import uart_pkg::*;
();

  localparam int clks_per_bit = 8; // short bit period for simulation

  typedef enum logic [1:0] {
    op_send,
    op_recv,
    op_led,
    op_unmapped
  } op_t;

  typedef struct {
    op_t          op;
    logic [4:0]   addr;     // unmapped reads only
    logic         cs;       // unmapped reads only
    logic [7:0]   data;     // byte, or led level in bit 0
    logic         rnd;      // data comes from the generator
    logic         stop;     // stop-bit level for receive
    uart_status_t exp_st;   // status after a receive
    logic [31:0]  exp_word; // expected d_out
  } step_t;

  logic        clk;
  logic        rst_n;
  logic [31:0] d_in;
  logic        cs;
  logic [4:0]  addr;
  logic        rd;
  logic        wr;
  logic        uart_rx;
  wire  [31:0] d_out;
  wire         uart_tx;
  wire         ledout;

  logic [31:0] rng = 32'h11cd_c132; // generator state
  logic        led_level = 1'b0;    // last led value written
  int          checks = 0;
  step_t       steps[$];

  uart_periph #(
    .clks_per_bit (clks_per_bit)
  ) DUT (
    .clk     (clk),
    .rst_n   (rst_n),
    .d_in    (d_in),
    .cs      (cs),
    .addr    (addr),
    .rd      (rd),
    .wr      (wr),
    .d_out   (d_out),
    .uart_tx (uart_tx),
    .uart_rx (uart_rx),
    .ledout  (ledout)
  );

  always #4 clk = ~clk; // 8 ns period

  function automatic logic [31:0] next_random(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13); // xorshift32
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("*** TEST FAILED ***");
    $fatal(1, "simulation stopped on error");
  endtask

  task automatic check_byte(input string name, input logic [7:0] got, input logic [7:0] exp);
    checks++;
    if (got !== exp) abort_run($sformatf("FAILED at %0t: %s got %h expected %h",
                                         $time, name, got, exp));
  endtask

  task automatic check_status(input string name, input uart_status_t got,
                              input uart_status_t exp);
    checks++;
    if (got !== exp) abort_run($sformatf("FAILED at %0t: %s got %b expected %b",
                                         $time, name, got, exp));
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    checks++;
    if (got !== exp) abort_run($sformatf("FAILED at %0t: %s got %b expected %b",
                                         $time, name, got, exp));
  endtask

  task automatic check_word(input string name, input logic [31:0] got, input logic [31:0] exp);
    checks++;
    if (got !== exp) abort_run($sformatf("FAILED at %0t: %s got %h expected %h",
                                         $time, name, got, exp));
  endtask

  task automatic bus_write(input logic [4:0] a, input logic [31:0] data);
    @(posedge clk);
    cs   <= 1'b1;
    wr   <= 1'b1;
    addr <= a;
    d_in <= data;
    @(posedge clk); // write lands on this edge
    cs   <= 1'b0;
    wr   <= 1'b0;
    d_in <= '0;
  endtask

  task automatic bus_read(input logic sel, input logic [4:0] a, output logic [31:0] data);
    @(posedge clk);
    cs   <= sel;
    rd   <= 1'b1;
    addr <= a;
    @(posedge clk); // d_out registered here
    cs   <= 1'b0;
    rd   <= 1'b0;
    @(negedge clk);
    data = d_out;
  endtask

  task automatic read_status(output uart_status_t st, output logic [31:0] word);
    bus_read(1'b1, `UART_ADDR_CTRL, word);
    st = word[9:7];
  endtask

  task automatic wait_tx_idle();
    uart_status_t st;
    logic [31:0]  w;
    int           n;
    n = 0;
    read_status(st, w);
    while (st.tx_busy) begin
      n++;
      if (n > 20 * clks_per_bit) abort_run("timeout: tx_busy never went low");
      read_status(st, w);
    end
  endtask

  task automatic wait_rx_avail(output uart_status_t st, output logic [31:0] w);
    int n;
    n = 0;
    read_status(st, w);
    while (!st.rx_avail) begin
      n++;
      if (n > 20 * clks_per_bit) abort_run("timeout: rx_avail never went high");
      read_status(st, w);
    end
  endtask

  // drive one frame on uart_rx, then hold the line idle
  task automatic drive_frame(input logic [7:0] b, input logic stop);
    logic [9:0] frame;
    frame = {stop, b, 1'b0};
    for (int i = 0; i < 10; i++) begin
      @(posedge clk);
      uart_rx <= frame[i];
      repeat (clks_per_bit - 1) @(posedge clk);
    end
    @(posedge clk);
    uart_rx <= 1'b1;
    repeat (2 * clks_per_bit) @(posedge clk);
  endtask

  // watch uart_tx, sample each bit near its middle
  task automatic capture_frame(output logic [7:0] b);
    int n;
    n = 0;
    while (uart_tx !== 1'b0) begin
      @(negedge clk);
      n++;
      if (n > 4 * clks_per_bit) abort_run("timeout: no start bit on uart_tx");
    end
    repeat (clks_per_bit / 2) @(negedge clk);
    check_bit("uart_tx start bit", uart_tx, 1'b0);
    for (int i = 0; i < 8; i++) begin
      repeat (clks_per_bit) @(negedge clk);
      b[i] = uart_tx; // lsb first
    end
    repeat (clks_per_bit) @(negedge clk);
    check_bit("uart_tx stop bit", uart_tx, 1'b1);
  endtask

  task automatic run_send(input logic [7:0] b);
    uart_status_t st;
    logic [31:0]  w;
    logic [7:0]   got;
    wait_tx_idle(); // poll before each send
    bus_write(`UART_ADDR_DATA, {24'd0, b});
    bus_write(`UART_ADDR_CTRL, {29'd0, led_level, 2'b10}); // tx_wr
    fork
      capture_frame(got);
      begin
        repeat (clks_per_bit) @(posedge clk);
        read_status(st, w);
        check_status("status during frame", st, 3'b100);
      end
    join
    check_byte("uart_tx byte", got, b);
    wait_tx_idle();
    read_status(st, w);
    check_status("status after frame", st, 3'b000);
    for (int i = 0; i < 2 * clks_per_bit; i++) begin
      @(negedge clk);
      check_bit("uart_tx idle after frame", uart_tx, 1'b1); // no repeat frame
    end
  endtask

  task automatic run_recv(input step_t s);
    uart_status_t st;
    logic [31:0]  w;
    drive_frame(s.data, s.stop);
    wait_rx_avail(st, w);
    check_status("status after receive", st, s.exp_st);
    check_word("d_out status word", w, {22'd0, s.exp_st, 7'd0});
    bus_read(1'b1, `UART_ADDR_DATA, w);
    check_byte("rx_data", w[7:0], s.data);
    check_word("d_out data word", w, s.exp_word);
    bus_write(`UART_ADDR_CTRL, {29'd0, led_level, 2'b01}); // rx_ack
    read_status(st, w);
    check_status("status after rx_ack", st, 3'b000);
    check_word("d_out after rx_ack", w, 32'd0);
  endtask

  task automatic build_table();
    step_t s;
    steps.push_back('{op_led, 5'd0, 1'b1, 8'h01, 1'b0, 1'b1, 3'b000, 32'd0});
    steps.push_back('{op_led, 5'd0, 1'b1, 8'h00, 1'b0, 1'b1, 3'b000, 32'd0});
    steps.push_back('{op_led, 5'd0, 1'b1, 8'h01, 1'b0, 1'b1, 3'b000, 32'd0});
    steps.push_back('{op_send, 5'd0, 1'b1, 8'ha5, 1'b0, 1'b1, 3'b000, 32'd0});
    steps.push_back('{op_recv, 5'd0, 1'b1, 8'h3c, 1'b0, 1'b1, 3'b000, 32'd0});
    steps.push_back('{op_recv, 5'd0, 1'b1, 8'hc3, 1'b0, 1'b0, 3'b000, 32'd0}); // bad stop
    steps.push_back('{op_recv, 5'd0, 1'b1, 8'h00, 1'b1, 1'b1, 3'b000, 32'd0});
    steps.push_back('{op_unmapped, 5'd3, 1'b1, 8'h5a, 1'b0, 1'b1, 3'b000, 32'd0});
    steps.push_back('{op_unmapped, 5'd31, 1'b1, 8'h96, 1'b0, 1'b1, 3'b000, 32'd0});
    steps.push_back('{op_unmapped, `UART_ADDR_DATA, 1'b0, 8'h69, 1'b0, 1'b1, 3'b000, 32'd0});
    steps.push_back('{op_unmapped, `UART_ADDR_CTRL, 1'b0, 8'he1, 1'b0, 1'b1, 3'b000, 32'd0});
    for (int i = 0; i < 4; i++) begin
      steps.push_back('{op_send, 5'd0, 1'b1, 8'h00, 1'b1, 1'b1, 3'b000, 32'd0}); // back to back
    end
    steps.push_back('{op_led, 5'd0, 1'b1, 8'h00, 1'b0, 1'b1, 3'b000, 32'd0});
    foreach (steps[i]) begin
      s = steps[i];
      if (s.rnd) begin
        rng    = next_random(rng);
        s.data = rng[7:0];
      end
      if (s.op == op_recv) begin
        s.exp_st   = {1'b0, 1'b1, ~s.stop}; // avail, error on low stop
        s.exp_word = {24'd0, s.data};
      end
      steps[i] = s;
    end
  endtask

  initial begin
    step_t        s;
    uart_status_t st;
    logic [31:0]  w;
    clk     = 1'b0;
    rst_n   = 1'b0;
    d_in    = '0;
    cs      = 1'b0;
    addr    = '0;
    rd      = 1'b0;
    wr      = 1'b0;
    uart_rx = 1'b1; // idle line
    build_table();
    repeat (3) @(posedge clk);
    rst_n <= 1'b1;
    @(negedge clk);
    check_bit("uart_tx after reset", uart_tx, 1'b1);
    check_bit("ledout after reset", ledout, 1'b0);
    check_word("d_out after reset", d_out, 32'd0);
    read_status(st, w);
    check_status("status after reset", st, 3'b000);
    foreach (steps[i]) begin
      s = steps[i];
      case (s.op)
        op_led: begin
          bus_write(`UART_ADDR_CTRL, {29'd0, s.data[0], 2'b00});
          led_level = s.data[0];
          @(negedge clk);
          check_bit("ledout", ledout, s.data[0]);
        end
        op_send: run_send(s.data);
        op_recv: run_recv(s);
        default: begin
          drive_frame(s.data, s.stop); // byte and rx_avail pending during the read
          wait_rx_avail(st, w);
          bus_read(s.cs, s.addr, w);
          check_word("d_out unmapped read", w, s.exp_word);
          bus_write(`UART_ADDR_CTRL, {29'd0, led_level, 2'b01}); // rx_ack
        end
      endcase
    end
    if (checks > 0) begin
      $display("*** TEST PASSED ***");
      $finish;
    end else begin
      abort_run("no checks were run");
    end
  end

endmodule

`default_nettype wire

//--- design/uart_periph.sv
`timescale 1ns/1ns
`default_nettype none

`include "uart_consts.svh"

module uart_periph #(
  parameter int clks_per_bit = `UART_CLKS_PER_BIT
) (
  input  wire         clk,
  input  wire         rst_n,
  input  wire  [31:0] d_in,
  input  wire         cs,
  input  wire  [4:0]  addr,
  input  wire         rd,
  input  wire         wr,
  output logic [31:0] d_out,
  output logic        uart_tx,
  input  wire         uart_rx,
  output logic        ledout
);

  uart_if bus_if ();  // regs <-> serial core

  uart_regs u_regs (
    .clk    (clk),
    .rst_n  (rst_n),
    .d_in   (d_in),
    .cs     (cs),
    .addr   (addr),
    .rd     (rd),
    .wr     (wr),
    .d_out  (d_out),
    .ledout (ledout),
    .bus    (bus_if.host)
  );

  uart_tx #(
    .clks_per_bit (clks_per_bit)
  ) u_tx (
    .clk   (clk),
    .rst_n (rst_n),
    .txd   (uart_tx),   // pin
    .bus   (bus_if.tx)
  );

  uart_rx #(
    .clks_per_bit (clks_per_bit)
  ) u_rx (
    .clk   (clk),
    .rst_n (rst_n),
    .rxd   (uart_rx),   // async pin, synced inside
    .bus   (bus_if.rx)
  );

endmodule

`default_nettype wire

//--- design/uart_regs.sv
`timescale 1ns/1ns
`default_nettype none

`include "uart_consts.svh"

module uart_regs
  import uart_pkg::*;
(
  input  wire         clk,
  input  wire         rst_n,
  input  wire  [31:0] d_in,
  input  wire         cs,
  input  wire  [4:0]  addr,
  input  wire         rd,     // kept for the bus, reads qualified by cs only
  input  wire         wr,
  output logic [31:0] d_out,
  output logic        ledout,
  uart_if.host        bus
);

  logic [1:0]   sel;       // bit 0 data reg, bit 1 ctrl reg
  logic [7:0]   tx_data_q; // byte to transmit
  uart_ctrl_u   ctrl;      // written raw, read by field
  uart_status_t status;

  // address decode, nothing selected without cs
  always_comb begin
    sel = 2'b00;
    if (cs) begin
      case (addr)
        `UART_ADDR_DATA: sel = 2'b01;
        `UART_ADDR_CTRL: sel = 2'b10;
        default:         sel = 2'b00;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (sel[0] && wr) begin
      tx_data_q <= d_in[7:0];
    end
  end

  // strobe bits fall back to zero one cycle after the write
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      ctrl.raw <= '0;
    end else if (sel[1] && wr) begin
      ctrl.raw <= d_in[7:0];
    end else begin
      ctrl.f.tx_wr  <= 1'b0;  // self-clear, no double send
      ctrl.f.rx_ack <= 1'b0;
    end
  end

  assign status.tx_busy  = bus.tx_busy;
  assign status.rx_avail = bus.rx_avail;
  assign status.rx_error = bus.rx_error;

  // registered read mux, zero for anything unmapped
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      d_out <= '0;
    end else begin
      case (sel)
        2'b01:   d_out <= {24'd0, bus.rx_data};
        2'b10:   d_out <= {22'd0, status, 7'd0}; // flags at 9:7
        default: d_out <= '0;
      endcase
    end
  end

  assign bus.tx_data = tx_data_q;
  assign bus.tx_wr   = ctrl.f.tx_wr;  // high exactly one cycle
  assign bus.rx_ack  = ctrl.f.rx_ack;
  assign ledout      = ctrl.f.led;    // level, held until rewritten

endmodule

`default_nettype wire

//--- design/uart_rx.sv
`timescale 1ns/1ns
`default_nettype none

`include "uart_consts.svh"

module uart_rx #(
  parameter int clks_per_bit = `UART_CLKS_PER_BIT
) (
  input  wire  clk,
  input  wire  rst_n,
  input  wire  rxd,
  uart_if.rx   bus
);

  localparam int cnt_w = (clks_per_bit > 1) ? $clog2(clks_per_bit) : 1;
  localparam logic [cnt_w-1:0] cnt_last = cnt_w'(clks_per_bit - 1);
  localparam logic [cnt_w-1:0] cnt_half = cnt_w'(clks_per_bit / 2 - 1);

  typedef enum logic [1:0] {
    st_idle,
    st_start,
    st_data,
    st_stop
  } rx_state_t;

  rx_state_t        state;
  logic             rx_meta;  // first sync stage
  logic             rx_sync;  // safe to use
  logic             rx_prev;  // for edge detect
  logic [cnt_w-1:0] baud_cnt; // clocks since last sample point
  logic [2:0]       bit_cnt;  // data bit index
  logic [7:0]       shreg;    // assembles the byte, lsb first
  logic [7:0]       data_q;
  logic             avail_q;
  logic             error_q;

  // 2-flop synchronizer plus one delay for the falling edge
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rx_meta <= 1'b1;
      rx_sync <= 1'b1;
      rx_prev <= 1'b1;
    end else begin
      rx_meta <= rxd;
      rx_sync <= rx_meta;
      rx_prev <= rx_sync;
    end
  end

  always_ff @(posedge clk) begin
    if (state == st_data && baud_cnt == cnt_last) begin
      shreg <= {rx_sync, shreg[7:1]}; // mid-bit sample
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state    <= st_idle;
      baud_cnt <= '0;
      bit_cnt  <= '0;
      data_q   <= '0;
      avail_q  <= 1'b0;
      error_q  <= 1'b0;
    end else begin
      if (bus.rx_ack) begin  // stop-bit load below wins if same cycle
        avail_q <= 1'b0;
        error_q <= 1'b0;
      end
      case (state)
        st_idle: begin
          baud_cnt <= '0;
          if (rx_prev && !rx_sync) begin
            state <= st_start;  // falling edge, maybe a start bit
          end
        end
        st_start: begin
          if (baud_cnt == cnt_half) begin  // middle of start bit
            baud_cnt <= '0;
            bit_cnt  <= '0;
            state    <= rx_sync ? st_idle : st_data; // high again is a glitch
          end else begin
            baud_cnt <= baud_cnt + 1'b1;
          end
        end
        st_data: begin
          if (baud_cnt == cnt_last) begin
            baud_cnt <= '0;
            if (bit_cnt == 3'd7) begin
              state <= st_stop;
            end
            bit_cnt <= bit_cnt + 3'd1;
          end else begin
            baud_cnt <= baud_cnt + 1'b1;
          end
        end
        default: begin  // st_stop
          if (baud_cnt == cnt_last) begin
            state   <= st_idle;
            data_q  <= shreg;     // overwrites an unread byte
            avail_q <= 1'b1;
            error_q <= !rx_sync;  // low stop bit, keep byte anyway
          end else begin
            baud_cnt <= baud_cnt + 1'b1;
          end
        end
      endcase
    end
  end

  assign bus.rx_data  = data_q;
  assign bus.rx_avail = avail_q;
  assign bus.rx_error = error_q;

endmodule

`default_nettype wire

//--- design/uart_tx.sv
`timescale 1ns/1ns
`default_nettype none

`include "uart_consts.svh"

module uart_tx #(
  parameter int clks_per_bit = `UART_CLKS_PER_BIT
) (
  input  wire  clk,
  input  wire  rst_n,
  output logic txd,
  uart_if.tx   bus
);

  // counter wide enough for clks_per_bit - 1
  localparam int cnt_w = (clks_per_bit > 1) ? $clog2(clks_per_bit) : 1;
  localparam logic [cnt_w-1:0] cnt_last = cnt_w'(clks_per_bit - 1);

  logic [9:0]       shreg;    // stop, data[7:0], start; lsb goes out first
  logic [3:0]       bit_cnt;  // bits already sent in this frame
  logic [cnt_w-1:0] baud_cnt; // clocks into current bit
  logic             busy;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      shreg    <= '1;       // idle line is high
      bit_cnt  <= '0;
      baud_cnt <= '0;
      busy     <= 1'b0;
    end else if (!busy) begin
      if (bus.tx_wr) begin  // pulse while busy is simply lost
        shreg    <= {1'b1, bus.tx_data, 1'b0};
        bit_cnt  <= '0;
        baud_cnt <= '0;
        busy     <= 1'b1;
      end
    end else if (baud_cnt == cnt_last) begin
      baud_cnt <= '0;
      shreg    <= {1'b1, shreg[9:1]}; // refill with idle level
      if (bit_cnt == 4'd9) begin
        busy <= 1'b0;                 // stop bit done, 10 periods total
      end else begin
        bit_cnt <= bit_cnt + 4'd1;
      end
    end else begin
      baud_cnt <= baud_cnt + 1'b1;
    end
  end

  assign txd         = shreg[0]; // straight from a flop, no glitches
  assign bus.tx_busy = busy;

endmodule

`default_nettype wire

//--- design/uart_if.sv
`timescale 1ns/1ns
`default_nettype none

// byte and strobe bundle between register block and serial core
interface uart_if;

  logic [7:0] tx_data;  // byte to send
  logic       tx_wr;    // one-cycle send request
  logic       tx_busy;  // frame in flight
  logic [7:0] rx_data;  // last byte received
  logic       rx_avail; // byte waiting
  logic       rx_error; // stop bit was low
  logic       rx_ack;   // one-cycle flag clear

  modport host (
    output tx_data,
    output tx_wr,
    output rx_ack,
    input  tx_busy,
    input  rx_data,
    input  rx_avail,
    input  rx_error
  );

  modport tx (
    input  tx_data,
    input  tx_wr,
    output tx_busy
  );

  modport rx (
    input  rx_ack,
    output rx_data,
    output rx_avail,
    output rx_error
  );

endinterface

`default_nettype wire

//--- design/uart_pkg.sv
`default_nettype none

package uart_pkg;

  // control byte as seen by field
  typedef struct packed {
    logic [4:0] rsvd;   // unused, reads back nothing
    logic       led;    // level, drives ledout
    logic       tx_wr;  // one-shot, start a transmit
    logic       rx_ack; // one-shot, drop rx flags
  } uart_ctrl_fields_t;

  // same byte, raw from the bus or split into fields
  typedef union packed {
    logic [7:0]        raw;
    uart_ctrl_fields_t f;
  } uart_ctrl_u;

  // status bits, placed at d_out[9:7]
  typedef struct packed {
    logic tx_busy;  // bit 9
    logic rx_avail; // bit 8
    logic rx_error; // bit 7
  } uart_status_t;

endpackage

`default_nettype wire

//--- design/uart_consts.svh
`ifndef UART_CONSTS_SVH
`define UART_CONSTS_SVH

// nominal system clock, hz
`define UART_CLK_FREQ 12000000

// serial line rate
`define UART_BAUD 9600

// default bit period in clocks, about 1250 at 12 MHz / 9600
`define UART_CLKS_PER_BIT (`UART_CLK_FREQ / `UART_BAUD)

// word addresses on the cpu bus
`define UART_ADDR_DATA 5'd8
`define UART_ADDR_CTRL 5'd16

`endif
